/* compile.f */
+incdir+.
matmul_pkg.sv
mac_unit.sv
processing_element.sv
pe_array.sv
operand_feeder.sv
matmul_sequencer.sv
result_drain.sv
matmul_top.sv
matmul_tb.sv

/* mac_unit.sv */
`default_nettype none

module mac_unit
    import matmul_pkg::*;
(
    input  logic                  clk,
    input  logic                  clear,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    output logic [DATA_WIDTH-1:0] acc
);

    logic [DATA_WIDTH-1:0] a_q;
    logic [DATA_WIDTH-1:0] b_q;
    logic [DATA_WIDTH-1:0] prod_q;

    // Operand register, product register, then the accumulator.
    // Everything wraps modulo 2**DATA_WIDTH
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            a_q    <= '0;
            b_q    <= '0;
            prod_q <= '0;
            acc    <= '0;
        end
        else
        begin
            a_q    <= a;
            b_q    <= b;
            prod_q <= DATA_WIDTH'(a_q * b_q);
            acc    <= acc + prod_q;
        end
    end

endmodule

`default_nettype wire

/* matmul_pkg.sv */
`default_nettype none

package matmul_pkg;

    //////////////////////////////////////////////////////////////////////
    // Tile geometry and pipeline depths
    //////////////////////////////////////////////////////////////////////

    // Operand and result element width
    localparam int DATA_WIDTH = 8;

    // Tile dimension, rows and columns of every matrix
    localparam int MAT_SIZE = 4;

    // Register stages between a PE input and its accumulator
    localparam int MAC_STAGES = 3;

    // Read latency of the external A and B memories
    localparam int MEM_LATENCY = 1;

    localparam int STRIDE_WIDTH = 8;
    localparam int CNT_WIDTH = 8;

    // Last operand pair enters PE(3,3) at count 3N-2, so the mesh has settled
    // once the MAC pipeline has drained past that point
    localparam int LATCH_CYCLE = 3 * MAT_SIZE - 1 + MAC_STAGES;

    // Count on which the last result column is on its way out
    localparam int DONE_CYCLE = LATCH_CYCLE + MAT_SIZE - 1;

    //////////////////////////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////////////////////////

    // One memory word, one result column or one skewed operand front.
    // Lane i is element i
    typedef logic [MAT_SIZE-1:0][DATA_WIDTH-1:0] lane_vec_t;

    // Validity masks. A cleared bit removes the matching row, inner index
    // or column from the product
    typedef struct packed {
        logic [MAT_SIZE-1:0] a_rows;
        logic [MAT_SIZE-1:0] k_valid;
        logic [MAT_SIZE-1:0] b_cols;
    } matmul_mask_t;

    // Sequencer state
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISHED
    } seq_state_t;

endpackage

`default_nettype wire

/* matmul_sequencer.sv */
`default_nettype none

module matmul_sequencer
    import matmul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_mat_mul,
    output logic [CNT_WIDTH-1:0] cnt,
    output logic                 row_latch,
    output logic                 done_mat_mul
);

    seq_state_t state;

    // The count reads 0 on the first cycle start is high and advances by one
    // every cycle after that. Dropping start returns everything to IDLE
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            state        <= IDLE;
            cnt          <= '0;
            done_mat_mul <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    state <= RUN;
                    cnt   <= cnt + 1'b1;
                end
                RUN:
                begin
                    cnt <= cnt + 1'b1;
                    // Registered, so the pulse lines up with the last column
                    if (cnt == CNT_WIDTH'(DONE_CYCLE))
                    begin
                        done_mat_mul <= 1'b1;
                        state        <= FINISHED;
                    end
                end
                FINISHED:
                begin
                    // Hold here until start drops
                    done_mat_mul <= 1'b0;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // All accumulators are final on this count
    assign row_latch = (state == RUN) && (cnt == CNT_WIDTH'(LATCH_CYCLE));

endmodule

`default_nettype wire

/* matmul_tb_ref.svh */
`ifndef MATMUL_TB_REF_SVH
`define MATMUL_TB_REF_SVH

// Element [row][col] of a 4x4 matrix of bytes
typedef logic [MAT_SIZE-1:0][MAT_SIZE-1:0][DATA_WIDTH-1:0] mat_t;

//////////////////////////////////////////////////////////////////////
// Reference multiply
//////////////////////////////////////////////////////////////////////

// C[i][j] sums A[i][k]*B[k][j] over the enabled inner indices, modulo 256.
// A masked row of A or column of B gives a zero element
function automatic mat_t ref_product(input mat_t a, input mat_t b, input matmul_mask_t m);
    mat_t                  c;
    logic [DATA_WIDTH-1:0] sum;
    c = '0;
    for (int i = 0; i < MAT_SIZE; i++)
    begin
        for (int j = 0; j < MAT_SIZE; j++)
        begin
            sum = '0;
            if (m.a_rows[i] && m.b_cols[j])
            begin
                for (int k = 0; k < MAT_SIZE; k++)
                begin
                    // 8-bit context, so the product wraps like the hardware
                    if (m.k_valid[k])
                        sum = sum + a[i][k] * b[k][j];
                end
            end
            c[i][j] = sum;
        end
    end
    return c;
endfunction

function automatic mat_t identity_matrix();
    mat_t m;
    m = '0;
    for (int i = 0; i < MAT_SIZE; i++)
        m[i][i] = DATA_WIDTH'(1);
    return m;
endfunction

//////////////////////////////////////////////////////////////////////
// Memory image helpers
//////////////////////////////////////////////////////////////////////

// Background pattern so that a stray read shows up as a wrong value
task automatic fill_memories();
    logic [ADDR_WIDTH-1:0] addr;
    for (int n = 0; n < MEM_DEPTH; n++)
    begin
        addr = ADDR_WIDTH'(n);
        for (int l = 0; l < MAT_SIZE; l++)
        begin
            mem_a[n][l] = addr[7:0] ^ {6'(l), addr[ADDR_WIDTH-1:DATA_WIDTH]};
            mem_b[n][l] = ~addr[7:0] ^ {6'(l), addr[ADDR_WIDTH-1:DATA_WIDTH]};
        end
    end
endtask

// Word k of the A image is column k of A
task automatic load_a(input mat_t a, input logic [ADDR_WIDTH-1:0] base,
                      input logic [STRIDE_WIDTH-1:0] stride);
    logic [ADDR_WIDTH-1:0] addr;
    for (int k = 0; k < MAT_SIZE; k++)
    begin
        addr = base + ADDR_WIDTH'(k * stride);
        for (int i = 0; i < MAT_SIZE; i++)
            mem_a[addr][i] = a[i][k];
    end
endtask

// Word k of the B image is row k of B
task automatic load_b(input mat_t b, input logic [ADDR_WIDTH-1:0] base,
                      input logic [STRIDE_WIDTH-1:0] stride);
    logic [ADDR_WIDTH-1:0] addr;
    for (int k = 0; k < MAT_SIZE; k++)
    begin
        addr = base + ADDR_WIDTH'(k * stride);
        for (int j = 0; j < MAT_SIZE; j++)
            mem_b[addr][j] = b[k][j];
    end
endtask

`endif

/* matmul_tb.sv */
`default_nettype none

module matmul_tb
    import matmul_pkg::*;
();

    localparam int ADDR_WIDTH = 10;
    localparam int MEM_DEPTH = 1 << ADDR_WIDTH;
    localparam int DONE_TIMEOUT = DONE_CYCLE + 40;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    start_mat_mul;
    logic                    done_mat_mul;
    logic [ADDR_WIDTH-1:0]   address_mat_a;
    logic [ADDR_WIDTH-1:0]   address_mat_b;
    logic [ADDR_WIDTH-1:0]   address_mat_c;
    logic [STRIDE_WIDTH-1:0] address_stride_a;
    logic [STRIDE_WIDTH-1:0] address_stride_b;
    logic [STRIDE_WIDTH-1:0] address_stride_c;
    lane_vec_t               a_data;
    lane_vec_t               b_data;
    matmul_mask_t            mask;
    logic [ADDR_WIDTH-1:0]   a_addr;
    logic [ADDR_WIDTH-1:0]   b_addr;
    logic [ADDR_WIDTH-1:0]   c_addr;
    lane_vec_t               c_data_out;
    logic                    c_data_available;

    lane_vec_t mem_a [MEM_DEPTH];
    lane_vec_t mem_b [MEM_DEPTH];

    int mismatch_count = 0;
    int failure_count = 0;

    `include "matmul_tb_ref.svh"

    // Expected result of the run in flight
    mat_t                    exp_c;
    logic [ADDR_WIDTH-1:0]   exp_c_base;
    logic [STRIDE_WIDTH-1:0] exp_c_stride;

    // Monitor bookkeeping
    int   since_start;
    int   beat_count;
    int   done_count;
    int   beat_idx;
    logic run_active;

    matmul_top #(.ADDR_WIDTH(ADDR_WIDTH)) dut_i (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .done_mat_mul     (done_mat_mul),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_mat_c    (address_mat_c),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .address_stride_c (address_stride_c),
        .a_data           (a_data),
        .b_data           (b_data),
        .mask             (mask),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available)
    );

    always #50 clk = ~clk;

    // Both memories answer one cycle after the address
    always @(posedge clk)
    begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        failure_count++;
    endtask

    task automatic report_and_finish();
        $display("Checks complete with %0d mismatches and %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////////////////////////

    // Counts edges from the first one that samples start high, so beat j
    // belongs on edge LATCH_CYCLE+1+j
    always @(posedge clk)
    begin
        if (reset)
        begin
            since_start = 0;
            beat_count  = 0;
            done_count  = 0;
            run_active  = 1'b0;
        end
        else if (!start_mat_mul)
        begin
            if (run_active && done_count != 1)
                report_failure($sformatf("run ended with %0d done pulses", done_count));
            if (run_active && beat_count != MAT_SIZE)
                report_failure($sformatf("run ended with %0d result beats", beat_count));
            if (c_data_available)
                report_failure("c_data_available is high while start is low");
            if (done_mat_mul)
                report_failure("done_mat_mul is high while start is low");
            since_start = 0;
            beat_count  = 0;
            done_count  = 0;
            run_active  = 1'b0;
        end
        else
        begin
            run_active = 1'b1;
            beat_idx   = since_start - (LATCH_CYCLE + 1);
            if (c_data_available)
            begin
                if (beat_idx < 0 || beat_idx >= MAT_SIZE)
                begin
                    report_failure($sformatf("result beat %0d cycles after start, outside window",
                                             since_start));
                end
                else
                begin
                    for (int i = 0; i < MAT_SIZE; i++)
                        check_value($sformatf("C[%0d][%0d]", i, beat_idx),
                                    c_data_out[i], exp_c[i][beat_idx]);
                    check_value($sformatf("c_addr on beat %0d", beat_idx), c_addr,
                                ADDR_WIDTH'(exp_c_base + beat_idx * exp_c_stride));
                end
                beat_count++;
            end
            else if (beat_idx >= 0 && beat_idx < MAT_SIZE)
            begin
                report_failure($sformatf("result beat %0d is missing", beat_idx));
            end
            if (done_mat_mul)
            begin
                done_count++;
                if (beat_idx != MAT_SIZE - 1 || !c_data_available)
                    report_failure("done_mat_mul does not line up with the last result beat");
            end
            since_start++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic mat_t random_matrix();
        mat_t        m;
        logic [31:0] rnd;
        for (int i = 0; i < MAT_SIZE; i++)
        begin
            for (int j = 0; j < MAT_SIZE; j++)
            begin
                rnd     = $urandom;
                m[i][j] = rnd[DATA_WIDTH-1:0];
            end
        end
        return m;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] pick_addr();
        logic [31:0] rnd;
        rnd = $urandom;
        return rnd[ADDR_WIDTH-1:0];
    endfunction

    // Never zero, so the four words of one matrix never overlap
    function automatic logic [STRIDE_WIDTH-1:0] pick_stride();
        logic [31:0] rnd;
        rnd = $urandom;
        return (rnd[STRIDE_WIDTH-1:0] == '0) ? STRIDE_WIDTH'(1) : rnd[STRIDE_WIDTH-1:0];
    endfunction

    // Start stays low for gap sampled edges, then one run goes to done
    task automatic run_matmul(input mat_t a, input mat_t b, input matmul_mask_t m,
                              input mat_t expected, input int gap);
        logic [ADDR_WIDTH-1:0]   a_base;
        logic [ADDR_WIDTH-1:0]   b_base;
        logic [ADDR_WIDTH-1:0]   c_base;
        logic [STRIDE_WIDTH-1:0] a_stride;
        logic [STRIDE_WIDTH-1:0] b_stride;
        logic [STRIDE_WIDTH-1:0] c_stride;
        logic                    seen;
        a_base   = pick_addr();
        b_base   = pick_addr();
        c_base   = pick_addr();
        a_stride = pick_stride();
        b_stride = pick_stride();
        c_stride = pick_stride();
        start_mat_mul    <= 1'b0;
        address_mat_a    <= a_base;
        address_mat_b    <= b_base;
        address_mat_c    <= c_base;
        address_stride_a <= a_stride;
        address_stride_b <= b_stride;
        address_stride_c <= c_stride;
        mask             <= m;
        @(posedge clk);
        load_a(a, a_base, a_stride);
        load_b(b, b_base, b_stride);
        exp_c        = expected;
        exp_c_base   = c_base;
        exp_c_stride = c_stride;
        for (int n = 1; n < gap; n++)
            @(posedge clk);
        start_mat_mul <= 1'b1;
        seen = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT && !seen; n++)
        begin
            @(posedge clk);
            seen = done_mat_mul;
        end
        if (!seen)
        begin
            report_failure("timed out waiting for done_mat_mul");
            report_and_finish();
        end
    endtask

    initial
    begin : stimulus
        mat_t         a_m;
        mat_t         b_m;
        matmul_mask_t full_mask;
        matmul_mask_t m;
        logic [31:0]  rnd;
        rnd = $urandom(32'hb452);
        full_mask        = '1;
        reset            = 1'b1;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = STRIDE_WIDTH'(1);
        address_stride_b = STRIDE_WIDTH'(1);
        address_stride_c = STRIDE_WIDTH'(1);
        mask             = full_mask;
        a_data           = '0;
        b_data           = '0;
        fill_memories();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("a_addr after reset", a_addr, address_mat_a);
        check_value("b_addr after reset", b_addr, address_mat_b);
        check_value("done_mat_mul after reset", done_mat_mul, 0);
        check_value("c_data_available after reset", c_data_available, 0);

        // Identity on the left hands back the right operand
        b_m = random_matrix();
        run_matmul(identity_matrix(), b_m, full_mask, b_m, 1);

        for (int r = 0; r < 3; r++)
        begin
            a_m = random_matrix();
            b_m = random_matrix();
            run_matmul(a_m, b_m, full_mask, ref_product(a_m, b_m, full_mask), 1);
        end

        // Rows of A and columns of B dropped
        m        = full_mask;
        m.a_rows = 4'b1011;
        m.b_cols = 4'b0110;
        a_m      = random_matrix();
        b_m      = random_matrix();
        run_matmul(a_m, b_m, m, ref_product(a_m, b_m, m), 2);

        // Inner terms 1 and 3 dropped
        m         = full_mask;
        m.k_valid = 4'b0101;
        a_m       = random_matrix();
        b_m       = random_matrix();
        run_matmul(a_m, b_m, m, ref_product(a_m, b_m, m), 1);

        // Random masks and gaps of one to four cycles between runs
        for (int r = 0; r < 4; r++)
        begin
            rnd = $urandom;
            m   = rnd[11:0];
            a_m = random_matrix();
            b_m = random_matrix();
            run_matmul(a_m, b_m, m, ref_product(a_m, b_m, m), 1 + int'(rnd[13:12]));
        end

        start_mat_mul <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        report_and_finish();
    end

endmodule

`default_nettype wire

/* matmul_top.sv */
`default_nettype none

module matmul_top
    import matmul_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_mat_mul,
    output logic                    done_mat_mul,
    input  logic [ADDR_WIDTH-1:0]   address_mat_a,
    input  logic [ADDR_WIDTH-1:0]   address_mat_b,
    input  logic [ADDR_WIDTH-1:0]   address_mat_c,
    input  logic [STRIDE_WIDTH-1:0] address_stride_a,
    input  logic [STRIDE_WIDTH-1:0] address_stride_b,
    input  logic [STRIDE_WIDTH-1:0] address_stride_c,
    input  lane_vec_t               a_data,
    input  lane_vec_t               b_data,
    input  matmul_mask_t            mask,
    output logic [ADDR_WIDTH-1:0]   a_addr,
    output logic [ADDR_WIDTH-1:0]   b_addr,
    output logic [ADDR_WIDTH-1:0]   c_addr,
    output lane_vec_t               c_data_out,
    output logic                    c_data_available
);

    logic [CNT_WIDTH-1:0] cnt;
    logic                 row_latch;
    lane_vec_t            a_front;
    lane_vec_t            b_front;
    lane_vec_t            result_cols [MAT_SIZE];

    matmul_sequencer seq_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .cnt           (cnt),
        .row_latch     (row_latch),
        .done_mat_mul  (done_mat_mul)
    );

    // A words are columns of A, so the lane mask selects rows of A
    operand_feeder #(.ADDR_WIDTH(ADDR_WIDTH)) a_feeder_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .cnt           (cnt),
        .base_addr     (address_mat_a),
        .stride        (address_stride_a),
        .mem_data      (a_data),
        .lane_mask     (mask.a_rows),
        .k_valid       (mask.k_valid),
        .mem_addr      (a_addr),
        .front         (a_front)
    );

    // B words are rows of B, so the lane mask selects columns of B
    operand_feeder #(.ADDR_WIDTH(ADDR_WIDTH)) b_feeder_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .cnt           (cnt),
        .base_addr     (address_mat_b),
        .stride        (address_stride_b),
        .mem_data      (b_data),
        .lane_mask     (mask.b_cols),
        .k_valid       (mask.k_valid),
        .mem_addr      (b_addr),
        .front         (b_front)
    );

    pe_array pe_array_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .a_front       (a_front),
        .b_front       (b_front),
        .result_cols   (result_cols)
    );

    result_drain #(.ADDR_WIDTH(ADDR_WIDTH)) drain_i (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .row_latch        (row_latch),
        .result_cols      (result_cols),
        .address_mat_c    (address_mat_c),
        .stride_c         (address_stride_c),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

`default_nettype wire

/* operand_feeder.sv */
`default_nettype none

module operand_feeder
    import matmul_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_mat_mul,
    input  logic [CNT_WIDTH-1:0]    cnt,
    input  logic [ADDR_WIDTH-1:0]   base_addr,
    input  logic [STRIDE_WIDTH-1:0] stride,
    input  lane_vec_t               mem_data,
    input  logic [MAT_SIZE-1:0]     lane_mask,
    input  logic [MAT_SIZE-1:0]     k_valid,
    output logic [ADDR_WIDTH-1:0]   mem_addr,
    output lane_vec_t               front
);

    localparam int K_WIDTH = $clog2(MAT_SIZE);

    logic                   access;
    logic [MEM_LATENCY-1:0] valid_pipe;
    logic                   word_valid;
    logic [K_WIDTH-1:0]     k_idx;
    lane_vec_t              masked;

    //////////////////////////////////////////////////////////////////////
    // Address generation and read tracking
    //////////////////////////////////////////////////////////////////////

    assign access = start_mat_mul && (cnt < CNT_WIDTH'(MAT_SIZE));

    // The base sits on the bus before start, so count 0 reads word 0
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || cnt >= CNT_WIDTH'(MAT_SIZE - 1))
            mem_addr <= base_addr;
        else
            mem_addr <= mem_addr + ADDR_WIDTH'(stride);
    end

    // Follows each read through the memory latency
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe[0] <= access;
            for (int s = 1; s < MEM_LATENCY; s++)
                valid_pipe[s] <= valid_pipe[s-1];
        end
    end

    assign word_valid = valid_pipe[MEM_LATENCY-1];

    // Inner index carried by the word now on mem_data
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
            k_idx <= '0;
        else if (word_valid)
            k_idx <= k_idx + 1'b1;
    end

    always_comb
    begin
        for (int i = 0; i < MAT_SIZE; i++)
        begin
            if (word_valid && k_valid[k_idx] && lane_mask[i])
                masked[i] = mem_data[i];
            else
                masked[i] = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Diagonal skew, lane i runs through i registers
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < MAT_SIZE; i++)
    begin : g_lane
        if (i == 0)
        begin : g_direct
            assign front[i] = masked[i];
        end
        else
        begin : g_delay
            logic [DATA_WIDTH-1:0] taps [i];

            always_ff @(posedge clk)
            begin
                if (reset || !start_mat_mul)
                begin
                    for (int t = 0; t < i; t++)
                        taps[t] <= '0;
                end
                else
                begin
                    taps[0] <= masked[i];
                    for (int t = 1; t < i; t++)
                        taps[t] <= taps[t-1];
                end
            end

            assign front[i] = taps[i-1];
        end
    end

endmodule

`default_nettype wire

/* pe_array.sv */
`default_nettype none

module pe_array
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  lane_vec_t a_front,
    input  lane_vec_t b_front,
    output lane_vec_t result_cols [MAT_SIZE]
);

    logic clear;

    // a_link[i][j] feeds PE(i,j) from the left, b_link[j][i] feeds it from above
    logic [DATA_WIDTH-1:0] a_link [MAT_SIZE][MAT_SIZE+1];
    logic [DATA_WIDTH-1:0] b_link [MAT_SIZE][MAT_SIZE+1];

    // Accumulators start from zero on every run
    assign clear = reset || !start_mat_mul;

    //////////////////////////////////////////////////////////////////////
    // Mesh edges
    //////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < MAT_SIZE; n++)
    begin : g_edge
        assign a_link[n][0] = a_front[n];
        assign b_link[n][0] = b_front[n];
    end

    //////////////////////////////////////////////////////////////////////
    // Processing elements, A moves right and B moves down
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < MAT_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < MAT_SIZE; j++)
        begin : g_col
            processing_element pe_i (
                .clk   (clk),
                .clear (clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[j][i]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[j][i+1]),
                .acc   (result_cols[j][i])
            );
        end
    end

endmodule

`default_nettype wire

/* processing_element.sv */
`default_nettype none

module processing_element
    import matmul_pkg::*;
(
    input  logic                  clk,
    input  logic                  clear,
    input  logic [DATA_WIDTH-1:0] in_a,
    input  logic [DATA_WIDTH-1:0] in_b,
    output logic [DATA_WIDTH-1:0] out_a,
    output logic [DATA_WIDTH-1:0] out_b,
    output logic [DATA_WIDTH-1:0] acc
);

    // One cycle per hop keeps the wavefront aligned across the mesh
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            out_a <= '0;
            out_b <= '0;
        end
        else
        begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    mac_unit mac_i (
        .clk   (clk),
        .clear (clear),
        .a     (in_a),
        .b     (in_b),
        .acc   (acc)
    );

endmodule

`default_nettype wire

/* result_drain.sv */
`default_nettype none

module result_drain
    import matmul_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_mat_mul,
    input  logic                    row_latch,
    input  lane_vec_t               result_cols [MAT_SIZE],
    input  logic [ADDR_WIDTH-1:0]   address_mat_c,
    input  logic [STRIDE_WIDTH-1:0] stride_c,
    output lane_vec_t               c_data_out,
    output logic [ADDR_WIDTH-1:0]   c_addr,
    output logic                    c_data_available
);

    localparam int BEAT_WIDTH = $clog2(MAT_SIZE);

    lane_vec_t             col_q [MAT_SIZE];
    logic [BEAT_WIDTH-1:0] beat;

    //////////////////////////////////////////////////////////////////////
    // Column shift register
    //////////////////////////////////////////////////////////////////////

    // Column 0 sits at the head, each beat moves the next one up
    always_ff @(posedge clk)
    begin
        if (row_latch)
        begin
            col_q <= result_cols;
        end
        else if (c_data_available)
        begin
            for (int j = 0; j < MAT_SIZE - 1; j++)
                col_q[j] <= col_q[j+1];
        end
    end

    assign c_data_out = col_q[0];

    //////////////////////////////////////////////////////////////////////
    // Beat counting and write addresses
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            c_data_available <= 1'b0;
            beat             <= '0;
            c_addr           <= address_mat_c;
        end
        else if (row_latch)
        begin
            c_data_available <= 1'b1;
            beat             <= '0;
            c_addr           <= address_mat_c;
        end
        else if (c_data_available)
        begin
            c_addr <= c_addr + ADDR_WIDTH'(stride_c);
            beat   <= beat + 1'b1;
            // Window closes after the last column
            if (beat == BEAT_WIDTH'(MAT_SIZE - 1))
                c_data_available <= 1'b0;
        end
    end

endmodule

`default_nettype wire
